/* design/id_ex_operand_reg.sv */
module id_ex_operand_reg (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             hold,
    input  logic                             stall,
    input  logic                             in_valid,
    input  logic [rvfwd_pkg::xlen-1:0]       in_rs1_val,
    input  logic [rvfwd_pkg::xlen-1:0]       in_rs2_val,
    input  logic [rvfwd_pkg::xlen-1:0]       in_store_data,
    input  logic [rvfwd_pkg::reg_addr_w-1:0] in_rd,
    output logic                             ex_valid_out,
    output logic [rvfwd_pkg::xlen-1:0]       ex_rs1_val,
    output logic [rvfwd_pkg::xlen-1:0]       ex_rs2_val,
    output logic [rvfwd_pkg::xlen-1:0]       ex_store_data,
    output logic [rvfwd_pkg::reg_addr_w-1:0] ex_rd_out
);

    // ******************************
    // ID/EX register
    // ******************************

    // priority is hold, then stall, then a normal capture
    // hold wins over stall so the backend sees a frozen entry, and the
    // stalled instruction is still at decode when hold drops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid_out  <= 1'b0;
            ex_rs1_val    <= '0;
            ex_rs2_val    <= '0;
            ex_store_data <= '0;
            ex_rd_out     <= '0;
        end else if (hold) begin
            // keep every field as it is
            ex_valid_out  <= ex_valid_out;
            ex_rs1_val    <= ex_rs1_val;
            ex_rs2_val    <= ex_rs2_val;
            ex_store_data <= ex_store_data;
            ex_rd_out     <= ex_rd_out;
        end else if (stall) begin
            // bubble: nothing valid goes to EX and no rd is claimed
            ex_valid_out  <= 1'b0;
            ex_rs1_val    <= '0;
            ex_rs2_val    <= '0;
            ex_store_data <= '0;
            ex_rd_out     <= '0;
        end else begin
            // an invalid slot passes through with its valid bit low
            ex_valid_out  <= in_valid;
            ex_rs1_val    <= in_rs1_val;
            ex_rs2_val    <= in_rs2_val;
            ex_store_data <= in_store_data;
            ex_rd_out     <= in_rd;
        end
    end

endmodule

/* design/inst_field_decode.sv */
module inst_field_decode (
    input  rvfwd_pkg::rv_inst_u               inst,
    output logic [rvfwd_pkg::reg_addr_w-1:0] rs1,
    output logic [rvfwd_pkg::reg_addr_w-1:0] rs2,
    output logic [rvfwd_pkg::reg_addr_w-1:0] rd,
    output logic                             uses_rs1,
    output logic                             uses_rs2,
    output logic                             is_store
);

    // source indices sit in the same bits in both views
    // rd only exists for opcodes that write back a result
    always_comb begin
        rs1      = inst.r.rs1;
        rs2      = inst.r.rs2;
        rd       = '0;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b0;
        is_store = 1'b0;
        case (inst.r.opcode)
            rvfwd_pkg::opc_op: begin
                rd       = inst.r.rd;
                uses_rs2 = 1'b1;
            end
            rvfwd_pkg::opc_op_imm,
            rvfwd_pkg::opc_load,
            rvfwd_pkg::opc_jalr: begin
                rd = inst.r.rd;
            end
            rvfwd_pkg::opc_lui,
            rvfwd_pkg::opc_auipc,
            rvfwd_pkg::opc_jal: begin
                // the rs1 bits belong to the immediate here
                rd       = inst.r.rd;
                uses_rs1 = 1'b0;
            end
            rvfwd_pkg::opc_store: begin
                // bits 11:7 are imm_lo in a store, so rd stays zero
                rs1      = inst.s.rs1;
                rs2      = inst.s.rs2;
                uses_rs2 = 1'b1;
                is_store = 1'b1;
            end
            rvfwd_pkg::opc_branch: begin
                // branches compare two sources and write nothing
                uses_rs2 = 1'b1;
            end
            default: begin
                // unknown opcodes read rs1 only and never claim a destination
                rd = '0;
            end
        endcase
    end

endmodule

/* design/load_use_hazard.sv */
module load_use_hazard (
    input  logic                             inst_valid,
    input  logic [rvfwd_pkg::reg_addr_w-1:0] rs1,
    input  logic [rvfwd_pkg::reg_addr_w-1:0] rs2,
    input  logic                             uses_rs1,
    input  logic                             uses_rs2,
    input  logic [rvfwd_pkg::reg_addr_w-1:0] ex_rd,
    input  logic                             ex_wen,
    input  logic                             ex_is_load,
    output logic                             stall_out
);

    // a load in EX only has its address on ex_result, so its data
    // cannot be forwarded yet and the consumer has to wait one cycle
    logic load_in_ex;
    logic rs1_clash;
    logic rs2_clash;

    // ******************************
    // producer side
    // ******************************

    // a load into x0 writes nothing and never blocks a reader
    assign load_in_ex = ex_is_load && ex_wen && (ex_rd != '0);

    // ******************************
    // consumer side
    // ******************************

    // only sources that the instruction really reads can clash
    assign rs1_clash = uses_rs1 && (rs1 == ex_rd);
    assign rs2_clash = uses_rs2 && (rs2 == ex_rd);

    // an empty decode slot never asks for a bubble
    assign stall_out = inst_valid && load_in_ex && (rs1_clash || rs2_clash);

endmodule

/* design/operand_forward.sv */
module operand_forward (
    input  logic [rvfwd_pkg::reg_addr_w-1:0] rs1,
    input  logic [rvfwd_pkg::reg_addr_w-1:0] rs2,
    input  logic                             uses_rs1,
    input  logic                             uses_rs2,
    input  logic                             is_store,
    input  logic [rvfwd_pkg::xlen-1:0]       rf_data1,
    input  logic [rvfwd_pkg::xlen-1:0]       rf_data2,
    input  logic [rvfwd_pkg::reg_addr_w-1:0] ex_rd,
    input  logic                             ex_wen,
    input  logic [rvfwd_pkg::xlen-1:0]       ex_result,
    input  logic [rvfwd_pkg::reg_addr_w-1:0] mem_rd,
    input  logic                             mem_wen,
    input  logic [rvfwd_pkg::xlen-1:0]       mem_result,
    input  logic [rvfwd_pkg::reg_addr_w-1:0] wb_rd,
    input  logic                             wb_wen,
    input  logic [rvfwd_pkg::xlen-1:0]       wb_result,
    output logic [rvfwd_pkg::xlen-1:0]       rs1_fwd,
    output logic [rvfwd_pkg::xlen-1:0]       rs2_fwd,
    output logic [rvfwd_pkg::xlen-1:0]       store_data,
    output logic [1:0]                       src1_sel,
    output logic [1:0]                       src2_sel
);

    // ******************************
    // source selection
    // ******************************

    // picks the youngest stage that will write src
    // x0 and an unused operand always stay on the register file path
    function automatic logic [1:0] fwd_code(
        input logic [rvfwd_pkg::reg_addr_w-1:0] src,
        input logic                             used,
        input logic [rvfwd_pkg::reg_addr_w-1:0] e_rd,
        input logic                             e_wen,
        input logic [rvfwd_pkg::reg_addr_w-1:0] m_rd,
        input logic                             m_wen,
        input logic [rvfwd_pkg::reg_addr_w-1:0] w_rd,
        input logic                             w_wen
    );
        logic [1:0] code;
        code = rvfwd_pkg::fwd_rf;
        if (used && (src != '0)) begin
            if (e_wen && (e_rd == src)) begin
                code = rvfwd_pkg::fwd_ex;
            end else if (m_wen && (m_rd == src)) begin
                code = rvfwd_pkg::fwd_mem;
            end else if (w_wen && (w_rd == src)) begin
                code = rvfwd_pkg::fwd_wb;
            end
        end
        return code;
    endfunction

    // turns a source code into the operand value, zero when not used
    function automatic logic [rvfwd_pkg::xlen-1:0] fwd_value(
        input logic [1:0]                 code,
        input logic                       used,
        input logic [rvfwd_pkg::xlen-1:0] rf_val,
        input logic [rvfwd_pkg::xlen-1:0] e_val,
        input logic [rvfwd_pkg::xlen-1:0] m_val,
        input logic [rvfwd_pkg::xlen-1:0] w_val
    );
        logic [rvfwd_pkg::xlen-1:0] val;
        case (code)
            rvfwd_pkg::fwd_ex:  val = e_val;
            rvfwd_pkg::fwd_mem: val = m_val;
            rvfwd_pkg::fwd_wb:  val = w_val;
            default:            val = rf_val;
        endcase
        if (!used) begin
            val = '0;
        end
        return val;
    endfunction

    // ******************************
    // operand paths
    // ******************************

    // each operand first picks its producer stage and then takes that value
    assign src1_sel = fwd_code(rs1, uses_rs1, ex_rd, ex_wen, mem_rd, mem_wen, wb_rd, wb_wen);
    assign src2_sel = fwd_code(rs2, uses_rs2, ex_rd, ex_wen, mem_rd, mem_wen, wb_rd, wb_wen);

    assign rs1_fwd = fwd_value(src1_sel, uses_rs1, rf_data1, ex_result, mem_result, wb_result);
    assign rs2_fwd = fwd_value(src2_sel, uses_rs2, rf_data2, ex_result, mem_result, wb_result);

    // a store sends its rs2 value on to memory, other instructions send nothing
    assign store_data = is_store ? rs2_fwd : '0;

endmodule

/* design/operand_read_stage.sv */
module operand_read_stage (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [31:0]                      inst,
    input  logic                             inst_valid,
    input  logic                             hold,
    input  logic [rvfwd_pkg::reg_addr_w-1:0] ex_rd,
    input  logic                             ex_wen,
    input  logic                             ex_is_load,
    input  logic [rvfwd_pkg::xlen-1:0]       ex_result,
    input  logic [rvfwd_pkg::reg_addr_w-1:0] mem_rd,
    input  logic                             mem_wen,
    input  logic [rvfwd_pkg::xlen-1:0]       mem_result,
    input  logic [rvfwd_pkg::reg_addr_w-1:0] wb_rd,
    input  logic                             wb_wen,
    input  logic [rvfwd_pkg::xlen-1:0]       wb_result,
    output logic                             stall_out,
    output logic [1:0]                       src1_sel,
    output logic [1:0]                       src2_sel,
    output logic                             ex_valid_out,
    output logic [rvfwd_pkg::xlen-1:0]       ex_rs1_val,
    output logic [rvfwd_pkg::xlen-1:0]       ex_rs2_val,
    output logic [rvfwd_pkg::xlen-1:0]       ex_store_data,
    output logic [rvfwd_pkg::reg_addr_w-1:0] ex_rd_out
);

    // decoded fields of the instruction in decode
    logic [rvfwd_pkg::reg_addr_w-1:0] rs1;
    logic [rvfwd_pkg::reg_addr_w-1:0] rs2;
    logic [rvfwd_pkg::reg_addr_w-1:0] rd;
    logic                             uses_rs1;
    logic                             uses_rs2;
    logic                             is_store;
    // raw register file values, and the values after forwarding
    logic [rvfwd_pkg::xlen-1:0]       rf_data1;
    logic [rvfwd_pkg::xlen-1:0]       rf_data2;
    logic [rvfwd_pkg::xlen-1:0]       rs1_fwd;
    logic [rvfwd_pkg::xlen-1:0]       rs2_fwd;
    logic [rvfwd_pkg::xlen-1:0]       store_data;

    // ******************************
    // decode and register read
    // ******************************

    inst_field_decode u_decode (
        .inst     (inst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .uses_rs1 (uses_rs1),
        .uses_rs2 (uses_rs2),
        .is_store (is_store)
    );

    // the WB stage is the only writer of the register file
    rv_regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rf_data1),
        .rdata2 (rf_data2),
        .wen    (wb_wen),
        .waddr  (wb_rd),
        .wdata  (wb_result)
    );

    // ******************************
    // forwarding and hazard
    // ******************************

    operand_forward u_forward (
        .rs1        (rs1),
        .rs2        (rs2),
        .uses_rs1   (uses_rs1),
        .uses_rs2   (uses_rs2),
        .is_store   (is_store),
        .rf_data1   (rf_data1),
        .rf_data2   (rf_data2),
        .ex_rd      (ex_rd),
        .ex_wen     (ex_wen),
        .ex_result  (ex_result),
        .mem_rd     (mem_rd),
        .mem_wen    (mem_wen),
        .mem_result (mem_result),
        .wb_rd      (wb_rd),
        .wb_wen     (wb_wen),
        .wb_result  (wb_result),
        .rs1_fwd    (rs1_fwd),
        .rs2_fwd    (rs2_fwd),
        .store_data (store_data),
        .src1_sel   (src1_sel),
        .src2_sel   (src2_sel)
    );

    load_use_hazard u_hazard (
        .inst_valid (inst_valid),
        .rs1        (rs1),
        .rs2        (rs2),
        .uses_rs1   (uses_rs1),
        .uses_rs2   (uses_rs2),
        .ex_rd      (ex_rd),
        .ex_wen     (ex_wen),
        .ex_is_load (ex_is_load),
        .stall_out  (stall_out)
    );

    // ******************************
    // ID/EX register
    // ******************************

    // the stall request turns the next entry into a bubble
    id_ex_operand_reg u_id_ex (
        .clk           (clk),
        .rst_n         (rst_n),
        .hold          (hold),
        .stall         (stall_out),
        .in_valid      (inst_valid),
        .in_rs1_val    (rs1_fwd),
        .in_rs2_val    (rs2_fwd),
        .in_store_data (store_data),
        .in_rd         (rd),
        .ex_valid_out  (ex_valid_out),
        .ex_rs1_val    (ex_rs1_val),
        .ex_rs2_val    (ex_rs2_val),
        .ex_store_data (ex_store_data),
        .ex_rd_out     (ex_rd_out)
    );

endmodule

/* design/rv_regfile.sv */
module rv_regfile (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [rvfwd_pkg::reg_addr_w-1:0] raddr1,
    input  logic [rvfwd_pkg::reg_addr_w-1:0] raddr2,
    output logic [rvfwd_pkg::xlen-1:0]       rdata1,
    output logic [rvfwd_pkg::xlen-1:0]       rdata2,
    input  logic                             wen,
    input  logic [rvfwd_pkg::reg_addr_w-1:0] waddr,
    input  logic [rvfwd_pkg::xlen-1:0]       wdata
);

    // only x1 to x31 have storage, x0 is a constant zero
    logic [rvfwd_pkg::xlen-1:0] regs [1:rvfwd_pkg::reg_depth-1];

    // ******************************
    // write port
    // ******************************

    // the write takes effect at the rising edge
    // a write addressed to x0 is dropped here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < rvfwd_pkg::reg_depth; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // ******************************
    // read ports
    // ******************************

    // reads are combinational and do not see a write in the same cycle
    // that case is covered by the WB forward in the operand mux
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

/* design/rvfwd_pkg.sv */
package rvfwd_pkg;

    // ******************************
    // widths and sizes
    // ******************************

    // data width of every architectural register and every stage result
    localparam int xlen = 64;
    // a register index is five bits, enough for x0 to x31
    localparam int reg_addr_w = 5;
    // number of architectural integer registers, x0 included
    localparam int reg_depth = 32;

    // ******************************
    // base ISA opcodes
    // ******************************

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;

    // ******************************
    // forwarding source codes
    // ******************************

    // the value came straight from the register file read port
    localparam logic [1:0] fwd_rf  = 2'd0;
    // the youngest producer, the instruction now in EX
    localparam logic [1:0] fwd_ex  = 2'd1;
    localparam logic [1:0] fwd_mem = 2'd2;
    // the oldest producer, whose write lands at the next edge
    localparam logic [1:0] fwd_wb  = 2'd3;

    // ******************************
    // instruction word
    // ******************************

    // one 32-bit word seen two ways; the S view puts imm_lo where R has rd
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [6:0]            imm_hi;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm_lo;
            logic [6:0]            opcode;
        } s;
    } rv_inst_u;

endpackage

/* dv/operand_read_props.sv */
module operand_read_props (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             hold,
    input logic                             stall_out,
    input logic                             ex_valid_out,
    input logic [rvfwd_pkg::xlen-1:0]       ex_rs1_val,
    input logic [rvfwd_pkg::xlen-1:0]       ex_rs2_val,
    input logic [rvfwd_pkg::xlen-1:0]       ex_store_data,
    input logic [rvfwd_pkg::reg_addr_w-1:0] ex_rd_out
);

    timeunit 1ns;
    timeprecision 100ps;

    // number of failed assertions so far in this run
    int unsigned assert_fails = 0;

    // the ID/EX register is cleared asynchronously, so no valid entry can exist in reset
    reset_clears_valid: assert property (@(posedge clk) !rst_n |-> !ex_valid_out)
        else begin
            assert_fails++;
            $error("ex_valid_out is high while rst_n is low");
        end

    // a load-use stall must put a bubble into EX unless the backend froze the register
    stall_gives_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        (stall_out && !hold) |=> !ex_valid_out)
        else begin
            assert_fails++;
            $error("a stall without hold did not produce a bubble");
        end

    // hold freezes every field of the ID/EX entry
    hold_keeps_entry: assert property (@(posedge clk) disable iff (!rst_n)
        hold |=> ($stable(ex_valid_out) && $stable(ex_rs1_val) && $stable(ex_rs2_val)
                  && $stable(ex_store_data) && $stable(ex_rd_out)))
        else begin
            assert_fails++;
            $error("the ID/EX entry changed while hold was high");
        end

endmodule

bind operand_read_stage operand_read_props u_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .hold          (hold),
    .stall_out     (stall_out),
    .ex_valid_out  (ex_valid_out),
    .ex_rs1_val    (ex_rs1_val),
    .ex_rs2_val    (ex_rs2_val),
    .ex_store_data (ex_store_data),
    .ex_rd_out     (ex_rd_out)
);

/* dv/operand_read_tb.sv */
module operand_read_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int reset_cycles  = 16;
    localparam int sweep_cycles  = 16;
    localparam int random_cycles = 2000;
    // reset, sweep, random run and drain, with some margin on top
    localparam int cycle_limit   = reset_cycles + sweep_cycles + random_cycles + 168;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst;
    logic        inst_valid;
    logic        hold;
    logic [4:0]  ex_rd;
    logic        ex_wen;
    logic        ex_is_load;
    logic [63:0] ex_result;
    logic [4:0]  mem_rd;
    logic        mem_wen;
    logic [63:0] mem_result;
    logic [4:0]  wb_rd;
    logic        wb_wen;
    logic [63:0] wb_result;
    logic        stall_out;
    logic [1:0]  src1_sel;
    logic [1:0]  src2_sel;
    logic        ex_valid_out;
    logic [63:0] ex_rs1_val;
    logic [63:0] ex_rs2_val;
    logic [63:0] ex_store_data;
    logic [4:0]  ex_rd_out;

    // model of the architectural registers, written only by WB
    logic [63:0] model_regs [0:31];
    // predicted ID/EX entry after the coming edge
    logic        exp_valid;
    logic [63:0] exp_rs1;
    logic [63:0] exp_rs2;
    logic [63:0] exp_store;
    logic [4:0]  exp_rd;
    // upstream must repeat its instruction after a hold or a stall
    logic        keep_inst;
    logic [31:0] lcg_state;
    int          err_count;
    int          check_count;
    int          cycle_count;

    operand_read_stage UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // numerical recipes constants, full 32-bit period
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [6:0] pick_opcode(input logic [31:0] r);
        case (r % 9)
            0: return rvfwd_pkg::opc_op;
            1: return rvfwd_pkg::opc_op_imm;
            2: return rvfwd_pkg::opc_load;
            3: return rvfwd_pkg::opc_store;
            4: return rvfwd_pkg::opc_branch;
            5: return rvfwd_pkg::opc_lui;
            6: return rvfwd_pkg::opc_auipc;
            7: return rvfwd_pkg::opc_jal;
            default: return rvfwd_pkg::opc_jalr;
        endcase
    endfunction

    task automatic check_value(input string test, input string field,
                               input logic [63:0] exp, input logic [63:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("[ERROR] %s %s: expected %0h, actual %0h at %0t",
                     test, field, exp, act, $time);
        end
    endtask

    // ******************************
    // stimulus
    // ******************************

    // reads two registers with no producer in flight
    task automatic drive_sweep(input int k);
        inst       <= {7'd0, 5'(2 * k + 1), 5'(2 * k), 3'd0, 5'd0, rvfwd_pkg::opc_op};
        inst_valid <= 1'b1;
        hold       <= 1'b0;
        ex_wen     <= 1'b0;
        ex_is_load <= 1'b0;
        mem_wen    <= 1'b0;
        wb_wen     <= 1'b0;
    endtask

    task automatic drive_random();
        logic [31:0] r;
        logic [31:0] f;
        logic [6:0]  op;
        r = lcg_next();
        f = lcg_next();
        if (!keep_inst) begin
            op = pick_opcode(r >> 8);
            // indices stay in x0 to x7, a store fills bits 11:7 with a full imm_lo
            inst <= {f[31:25], 2'b00, f[2:0], 2'b00, f[5:3], f[8:6],
                     (op == rvfwd_pkg::opc_store) ? f[13:9] : {2'b00, f[11:9]}, op};
            inst_valid <= (r[31:29] != 3'd0);
        end
        r = lcg_next();
        ex_rd      <= {2'b00, r[2:0]};
        mem_rd     <= {2'b00, r[5:3]};
        wb_rd      <= {2'b00, r[8:6]};
        ex_wen     <= r[9];
        mem_wen    <= r[10];
        wb_wen     <= r[11] | r[12];
        ex_is_load <= r[13] & r[14];
        hold       <= (r[17:15] == 3'd0);
        ex_result  <= {lcg_next(), lcg_next()};
        mem_result <= {lcg_next(), lcg_next()};
        wb_result  <= {lcg_next(), lcg_next()};
    endtask

    // ******************************
    // reference model
    // ******************************

    function automatic logic [1:0] model_source(input logic [4:0] idx, input logic used);
        logic [1:0] sel;
        sel = rvfwd_pkg::fwd_rf;
        // walk from the oldest producer to the youngest so the youngest overwrites
        if (used && (idx != 5'd0)) begin
            if (wb_wen && (wb_rd == idx)) sel = rvfwd_pkg::fwd_wb;
            if (mem_wen && (mem_rd == idx)) sel = rvfwd_pkg::fwd_mem;
            if (ex_wen && (ex_rd == idx)) sel = rvfwd_pkg::fwd_ex;
        end
        return sel;
    endfunction

    function automatic logic [63:0] model_value(input logic [4:0] idx, input logic used);
        logic [1:0]  sel;
        logic [63:0] v;
        sel = model_source(idx, used);
        v = model_regs[idx];
        if (sel == rvfwd_pkg::fwd_ex) v = ex_result;
        if (sel == rvfwd_pkg::fwd_mem) v = mem_result;
        if (sel == rvfwd_pkg::fwd_wb) v = wb_result;
        if (!used) v = 64'd0;
        return v;
    endfunction

    // checks the last captured entry and the present decode, then predicts the next entry
    task automatic step_model(input string test);
        logic [6:0]  op;
        logic [4:0]  s1;
        logic [4:0]  s2;
        logic        use1;
        logic        use2;
        logic        store;
        logic        stall;
        logic [63:0] v2;
        check_value(test, "ex_valid_out", exp_valid, ex_valid_out);
        check_value(test, "ex_rs1_val", exp_rs1, ex_rs1_val);
        check_value(test, "ex_rs2_val", exp_rs2, ex_rs2_val);
        check_value(test, "ex_store_data", exp_store, ex_store_data);
        check_value(test, "ex_rd_out", exp_rd, ex_rd_out);
        op    = inst[6:0];
        s1    = inst[19:15];
        s2    = inst[24:20];
        use1  = !(op == rvfwd_pkg::opc_lui || op == rvfwd_pkg::opc_auipc
                  || op == rvfwd_pkg::opc_jal);
        use2  = (op == rvfwd_pkg::opc_op || op == rvfwd_pkg::opc_store
                 || op == rvfwd_pkg::opc_branch);
        store = (op == rvfwd_pkg::opc_store);
        stall = inst_valid && ex_is_load && ex_wen && (ex_rd != 5'd0)
                && ((use1 && (s1 == ex_rd)) || (use2 && (s2 == ex_rd)));
        check_value(test, "stall_out", stall, stall_out);
        check_value(test, "src1_sel", model_source(s1, use1), src1_sel);
        check_value(test, "src2_sel", model_source(s2, use2), src2_sel);
        v2 = model_value(s2, use2);
        if (!hold && stall) begin
            exp_valid = 1'b0;
            exp_rs1   = 64'd0;
            exp_rs2   = 64'd0;
            exp_store = 64'd0;
            exp_rd    = 5'd0;
        end else if (!hold) begin
            exp_valid = inst_valid;
            exp_rs1   = model_value(s1, use1);
            exp_rs2   = v2;
            exp_store = store ? v2 : 64'd0;
            exp_rd    = (store || op == rvfwd_pkg::opc_branch) ? 5'd0 : inst[11:7];
        end
        keep_inst = hold || stall;
        // the write lands at the coming edge, after this cycle's reads
        if (wb_wen && (wb_rd != 5'd0)) begin
            model_regs[wb_rd] = wb_result;
        end
    endtask

    // ******************************
    // main sequence
    // ******************************

    initial begin
        lcg_state   = 32'hbfd6_41f7;
        err_count   = 0;
        check_count = 0;
        keep_inst   = 1'b0;
        exp_valid   = 1'b0;
        exp_rs1     = 64'd0;
        exp_rs2     = 64'd0;
        exp_store   = 64'd0;
        exp_rd      = 5'd0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 64'd0;
        end
        rst_n      = 1'b0;
        inst       = 32'd0;
        inst_valid = 1'b0;
        hold       = 1'b0;
        ex_rd      = 5'd0;
        ex_wen     = 1'b0;
        ex_is_load = 1'b0;
        ex_result  = 64'd0;
        mem_rd     = 5'd0;
        mem_wen    = 1'b0;
        mem_result = 64'd0;
        wb_rd      = 5'd0;
        wb_wen     = 1'b0;
        wb_result  = 64'd0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("reset", "ex_valid_out", 64'd0, ex_valid_out);
        check_value("reset", "ex_rd_out", 64'd0, ex_rd_out);
        // every register must read zero right after reset
        for (int k = 0; k < sweep_cycles; k++) begin
            @(posedge clk);
            drive_sweep(k);
            @(negedge clk);
            step_model("sweep");
        end
        for (int n = 0; n < random_cycles; n++) begin
            @(posedge clk);
            drive_random();
            @(negedge clk);
            step_model("random");
        end
        // one quiet cycle so the last prediction gets compared
        @(posedge clk);
        inst_valid <= 1'b0;
        hold       <= 1'b0;
        ex_wen     <= 1'b0;
        @(negedge clk);
        step_model("drain");
        $display("checks: %0d, value errors: %0d, assertion failures: %0d",
                 check_count, err_count, UUT.u_props.assert_fails);
        if (err_count == 0 && UUT.u_props.assert_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog on the total number of clock cycles
    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= cycle_limit) begin
                $display("timeout: the run did not finish within %0d cycles", cycle_limit);
                $display("SIMULATION FAILED");
                $finish;
            end
        end
    end

endmodule

/* tb.f */
design/rvfwd_pkg.sv
design/rv_regfile.sv
design/inst_field_decode.sv
design/operand_forward.sv
design/load_use_hazard.sv
design/id_ex_operand_reg.sv
design/operand_read_stage.sv
dv/operand_read_props.sv
dv/operand_read_tb.sv
